//--- Makefile
TOP := mwfifo_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ns -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --timescale 1ns/1ns -f filelist.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

//--- design/fifo_flopped.sv
`timescale 1ns/1ns

module fifo_flopped #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 2
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     single_push,
  input  payload_t fifo_in_data,
  input  logic     single_pop,
  output payload_t fifo_out_data,
  output logic     fifo_full,
  output logic     fifo_empty,
  output logic     fifo_idle
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payload_t        mem [DEPTH];
  logic [AW-1:0]   wr_ptr;
  logic [AW-1:0]   rd_ptr;
  logic [CW-1:0]   count;
  logic            do_push;
  logic            do_pop;

  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
    next_ptr = (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign fifo_full  = (count == CW'(DEPTH));
  assign fifo_empty = (count == '0);
  assign fifo_idle  = fifo_empty && !single_push && !single_pop;

  // Overflow and underflow requests are dropped
  assign do_push = single_push && !fifo_full;
  assign do_pop  = single_pop && !fifo_empty;

  // Head is read straight from the array
  assign fifo_out_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= fifo_in_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- design/fifo_flopped_4w2r.sv
`timescale 1ns/1ns
`include "mwfifo_macros.svh"

module fifo_flopped_4w2r (
  input  logic                      clk,
  input  logic                      rst_n,
  input  mwfifo_pkg::wr_lanes_t     push_lanes,
  input  logic                      pop0,
  input  logic                      pop1,
  output mwfifo_pkg::entry_t        out_data0,
  output mwfifo_pkg::entry_t        out_data1,
  output mwfifo_pkg::fill_flags_t   flags
);

  localparam int NBANK     = `MWFIFO_WLANES;
  localparam int DEPTH_SUB = `MWFIFO_DEPTH / NBANK;

  mwfifo_pkg::entry_t lane_data [NBANK];
  mwfifo_pkg::entry_t bank_in   [NBANK];
  mwfifo_pkg::entry_t bank_out  [NBANK];
  logic [NBANK-1:0]   bank_push;
  logic [NBANK-1:0]   bank_pop;
  logic [NBANK-1:0]   bank_full;
  logic [NBANK-1:0]   bank_empty;
  logic [NBANK-1:0]   bank_idle;

  logic [1:0] push_ptr;
  logic [1:0] push_ptr_nxt;
  logic [2:0] push_cnt;
  logic [1:0] pop_ptr;
  logic [1:0] pop_ptr_p1;
  logic [1:0] pop_ptr_nxt;
  logic [2:0] full_cnt;
  logic [2:0] busy_cnt;

  assign lane_data[0] = push_lanes.data0;
  assign lane_data[1] = push_lanes.data1;
  assign lane_data[2] = push_lanes.data2;
  assign lane_data[3] = push_lanes.data3;

  // Push start pointer moves by the number of entries written
  always_comb begin
    push_cnt = '0;
    for (int k = 0; k < NBANK; k++) begin
      push_cnt = push_cnt + 3'(push_lanes.valid[k]);
    end
  end

  assign push_ptr_nxt = push_ptr + push_cnt[1:0];

  // Pop start pointer moves by one or two
  assign pop_ptr_p1  = pop_ptr + 2'd1;
  assign pop_ptr_nxt = pop1 ? pop_ptr + 2'd2 : pop_ptr_p1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      push_ptr <= '0;
      pop_ptr  <= '0;
    end else begin
      if (|push_lanes.valid) begin
        push_ptr <= push_ptr_nxt;
      end
      if (pop0) begin
        pop_ptr <= pop_ptr_nxt;
      end
    end
  end

  // Lane k lands on bank push_ptr+k
  always_comb begin
    logic [1:0] lane;
    for (int b = 0; b < NBANK; b++) begin
      lane         = 2'(b) - push_ptr;
      bank_push[b] = push_lanes.valid[lane];
      bank_in[b]   = lane_data[lane];
      bank_pop[b]  = (pop0 && (2'(b) == pop_ptr)) || (pop1 && (2'(b) == pop_ptr_p1));
    end
  end

  // Oldest entry sits in the bank at the pop pointer
  assign out_data0 = bank_out[pop_ptr];
  assign out_data1 = bank_out[pop_ptr_p1];

  // Banks differ by at most one entry, so counting banks is enough
  always_comb begin
    full_cnt = '0;
    busy_cnt = '0;
    for (int b = 0; b < NBANK; b++) begin
      full_cnt = full_cnt + 3'(bank_full[b]);
      busy_cnt = busy_cnt + 3'(!bank_empty[b]);
    end
  end

  assign flags.full        = (full_cnt == 3'd4);
  assign flags.left1_full  = (full_cnt == 3'd3);
  assign flags.left2_full  = (full_cnt == 3'd2);
  assign flags.left3_full  = (full_cnt == 3'd1);
  assign flags.empty       = (busy_cnt == 3'd0);
  assign flags.left1_empty = (busy_cnt == 3'd1);
  assign flags.idle        = &bank_idle;

  // Bank b holds entries b, b+4, b+8 ...
  for (genvar b = 0; b < NBANK; b++) begin : g_bank
    fifo_flopped #(
      .payload_t (mwfifo_pkg::entry_t),
      .DEPTH     (DEPTH_SUB)
    ) u_bank (
      .clk           (clk),
      .rst_n         (rst_n),
      .single_push   (bank_push[b]),
      .fifo_in_data  (bank_in[b]),
      .single_pop    (bank_pop[b]),
      .fifo_out_data (bank_out[b]),
      .fifo_full     (bank_full[b]),
      .fifo_empty    (bank_empty[b]),
      .fifo_idle     (bank_idle[b])
    );
  end

endmodule

//--- design/mwfifo_macros.svh
`ifndef MWFIFO_MACROS_SVH
`define MWFIFO_MACROS_SVH

// Width of one FIFO entry in bits
`define MWFIFO_DWIDTH 32

// Total entries over all four banks, a multiple of 4
`define MWFIFO_DEPTH 8

// Producer write lanes, also the number of banks
`define MWFIFO_WLANES 4

// Consumer read lanes
`define MWFIFO_RLANES 2

`endif

//--- design/mwfifo_pkg.sv
`include "mwfifo_macros.svh"

package mwfifo_pkg;

  typedef logic [`MWFIFO_DWIDTH-1:0] entry_t;

  // Lower lane is the older entry
  typedef struct packed {
    logic [`MWFIFO_WLANES-1:0] valid;
    entry_t                    data3;
    entry_t                    data2;
    entry_t                    data1;
    entry_t                    data0;
  } wr_lanes_t;

  typedef struct packed {
    logic [`MWFIFO_RLANES-1:0] valid;
    entry_t                    data1;
    entry_t                    data0;
  } rd_lanes_t;

  typedef struct packed {
    logic full;
    logic left1_full;
    logic left2_full;
    logic left3_full;
    logic empty;
    logic left1_empty;
    logic idle;
  } fill_flags_t;

endpackage

//--- design/mwfifo_top.sv
`timescale 1ns/1ns

module mwfifo_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  mwfifo_pkg::wr_lanes_t wr,
  output logic                  in_ready,
  output mwfifo_pkg::rd_lanes_t rd,
  input  logic                  rd_ready,
  output logic                  idle
);

  mwfifo_pkg::wr_lanes_t   push_lanes;
  mwfifo_pkg::fill_flags_t flags;
  mwfifo_pkg::entry_t      out_data0;
  mwfifo_pkg::entry_t      out_data1;
  logic                    pop0;
  logic                    pop1;

  assign idle = flags.idle;

  wide_push_packer u_packer (
    .wr         (wr),
    .flags      (flags),
    .in_ready   (in_ready),
    .push_lanes (push_lanes)
  );

  fifo_flopped_4w2r u_core (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_lanes (push_lanes),
    .pop0       (pop0),
    .pop1       (pop1),
    .out_data0  (out_data0),
    .out_data1  (out_data1),
    .flags      (flags)
  );

  pop_issuer u_pop (
    .flags     (flags),
    .out_data0 (out_data0),
    .out_data1 (out_data1),
    .rd_ready  (rd_ready),
    .pop0      (pop0),
    .pop1      (pop1),
    .rd        (rd)
  );

endmodule

//--- design/pop_issuer.sv
`timescale 1ns/1ns

module pop_issuer (
  input  mwfifo_pkg::fill_flags_t flags,
  input  mwfifo_pkg::entry_t      out_data0,
  input  mwfifo_pkg::entry_t      out_data1,
  input  logic                    rd_ready,
  output logic                    pop0,
  output logic                    pop1,
  output mwfifo_pkg::rd_lanes_t   rd
);

  logic [1:0] rd_valid;

  // Second lane needs at least two entries
  assign rd_valid[0] = !flags.empty;
  assign rd_valid[1] = !flags.empty && !flags.left1_empty;

  assign rd.valid = rd_valid;
  assign rd.data0 = out_data0;
  assign rd.data1 = out_data1;

  // pop1 never rises without pop0
  assign pop0 = rd_valid[0] && rd_ready;
  assign pop1 = rd_valid[1] && rd_ready;

endmodule

//--- design/wide_push_packer.sv
`timescale 1ns/1ns
`include "mwfifo_macros.svh"

module wide_push_packer (
  input  mwfifo_pkg::wr_lanes_t   wr,
  input  mwfifo_pkg::fill_flags_t flags,
  output logic                    in_ready,
  output mwfifo_pkg::wr_lanes_t   push_lanes
);

  localparam int NLANE = `MWFIFO_WLANES;

  mwfifo_pkg::entry_t in_data     [NLANE];
  mwfifo_pkg::entry_t packed_data [NLANE];
  logic [NLANE-1:0]   packed_valid;

  assign in_data[0] = wr.data0;
  assign in_data[1] = wr.data1;
  assign in_data[2] = wr.data2;
  assign in_data[3] = wr.data3;

  // Any bank full blocks the whole group
  assign in_ready = !(flags.full || flags.left1_full ||
                      flags.left2_full || flags.left3_full);

  // Each valid lane goes to the slot given by the valid lanes below it
  always_comb begin
    logic [2:0] cnt;
    cnt = '0;
    for (int j = 0; j < NLANE; j++) begin
      packed_data[j] = '0;
    end
    for (int i = 0; i < NLANE; i++) begin
      if (wr.valid[i]) begin
        packed_data[cnt[1:0]] = in_data[i];
        cnt = cnt + 3'd1;
      end
    end
    for (int j = 0; j < NLANE; j++) begin
      packed_valid[j] = (3'(j) < cnt);
    end
  end

  assign push_lanes.valid = in_ready ? packed_valid : '0;
  assign push_lanes.data0 = packed_data[0];
  assign push_lanes.data1 = packed_data[1];
  assign push_lanes.data2 = packed_data[2];
  assign push_lanes.data3 = packed_data[3];

endmodule

//--- dv/mwfifo_tb.sv
`timescale 1ns/1ns
`include "mwfifo_macros.svh"

module mwfifo_tb;

  localparam int DEPTH       = `MWFIFO_DEPTH;
  localparam int N_FULL      = 40;
  localparam int N_SPARSE    = 24;
  localparam int N_RAND      = 400;
  localparam int STIM_CYCLES = 20 + 2 * N_FULL + 2 * N_SPARSE + N_RAND;
  localparam int TIMEOUT     = STIM_CYCLES * 4 + 100;

  localparam logic [3:0] SPARSE_PAT [12] = '{
    4'b1010, 4'b0101, 4'b0001, 4'b1000, 4'b0110, 4'b1001,
    4'b1110, 4'b0111, 4'b0000, 4'b1011, 4'b0100, 4'b1101
  };

  logic                    clk;
  logic                    rst_n;
  mwfifo_pkg::wr_lanes_t   wr;
  logic                    in_ready;
  mwfifo_pkg::rd_lanes_t   rd;
  logic                    rd_ready;
  logic                    idle;

  mwfifo_pkg::entry_t      model_q [$];
  integer                  seed = 32'h5213;
  int                      err_cnt;
  int                      test_cnt;
  int                      test_fail_cnt;
  int                      test_err_start;
  int                      cycle_cnt;

  tb_clkgen u_clkgen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  mwfifo_top mwfifo_top_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr       (wr),
    .in_ready (in_ready),
    .rd       (rd),
    .rd_ready (rd_ready),
    .idle     (idle)
  );

  // Valid lanes of an accepted group go in lower lane first
  function automatic void append_lanes(input mwfifo_pkg::wr_lanes_t w);
    mwfifo_pkg::entry_t d [4];
    d[0] = w.data0;
    d[1] = w.data1;
    d[2] = w.data2;
    d[3] = w.data3;
    for (int i = 0; i < 4; i++) begin
      if (w.valid[i]) begin
        model_q.push_back(d[i]);
      end
    end
  endfunction

  function automatic mwfifo_pkg::wr_lanes_t rand_group(input logic [3:0] valid);
    mwfifo_pkg::wr_lanes_t g;
    g.valid = valid;
    g.data0 = $random(seed);
    g.data1 = $random(seed);
    g.data2 = $random(seed);
    g.data3 = $random(seed);
    return g;
  endfunction

  // Outputs are stable at the falling edge and describe the next rising edge
  always @(negedge clk) begin : compare
    int                 n;
    logic [1:0]         exp_valid;
    logic               exp_idle;
    mwfifo_pkg::entry_t exp_data;
    if (rst_n) begin
      n = model_q.size();
      exp_valid = {n >= 2, n >= 1};
      if (rd.valid !== exp_valid) begin
        $display("Mismatch rd.valid: expected %h, actual %h", exp_valid, rd.valid);
        err_cnt++;
      end
      // Empty with nothing written this cycle
      exp_idle = (n == 0) && !(in_ready && (|wr.valid));
      if (idle !== exp_idle) begin
        $display("Mismatch idle: expected %h, actual %h", exp_idle, idle);
        err_cnt++;
      end
      if (!in_ready && n < 4) begin
        $display("in_ready is low while only %0d entries are stored", n);
        err_cnt++;
      end
      if (in_ready && n > DEPTH - 4) begin
        $display("in_ready is high with %0d entries stored, a full group would overflow", n);
        err_cnt++;
      end
      if (rd_ready) begin
        if (rd.valid[0] && model_q.size() > 0) begin
          exp_data = model_q.pop_front();
          if (rd.data0 !== exp_data) begin
            $display("Mismatch rd.data0: expected %h, actual %h", exp_data, rd.data0);
            err_cnt++;
          end
        end
        if (rd.valid[1] && model_q.size() > 0) begin
          exp_data = model_q.pop_front();
          if (rd.data1 !== exp_data) begin
            $display("Mismatch rd.data1: expected %h, actual %h", exp_data, rd.data1);
            err_cnt++;
          end
        end
      end
      if (in_ready) begin
        append_lanes(wr);
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT) begin
      $display("Timeout: run went past %0d cycles without finishing", TIMEOUT);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // Holds the group until an edge with in_ready high takes it
  task automatic send_group(input mwfifo_pkg::wr_lanes_t g);
    bit accepted;
    accepted = 1'b0;
    wr = g;
    while (!accepted) begin
      @(negedge clk);
      accepted = in_ready;
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_drain();
    while (model_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic start_test();
    test_err_start = err_cnt;
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = err_cnt - test_err_start;
    test_cnt++;
    if (errs != 0) begin
      test_fail_cnt++;
    end
    $display("test %0d %s finished with %0d errors", test_cnt, name, errs);
  endtask

  initial begin : stimulus
    mwfifo_pkg::wr_lanes_t g;
    integer                r;
    bit                    pending;
    bit                    saw_low;
    err_cnt       = 0;
    test_cnt      = 0;
    test_fail_cnt = 0;
    cycle_cnt     = 0;
    wr            = '0;
    rd_ready      = 1'b0;
    @(posedge rst_n);
    @(posedge clk);
    #1;

    start_test();
    @(negedge clk);
    if (in_ready !== 1'b1) begin
      $display("Mismatch in_ready: expected 1, actual %h", in_ready);
      err_cnt++;
    end
    if (idle !== 1'b1) begin
      $display("Mismatch idle: expected 1, actual %h", idle);
      err_cnt++;
    end
    if (rd.valid !== 2'b00) begin
      $display("Mismatch rd.valid: expected 0, actual %h", rd.valid);
      err_cnt++;
    end
    @(posedge clk);
    #1;
    finish_test("reset_state");

    start_test();
    rd_ready = 1'b1;
    for (int i = 0; i < N_FULL; i++) begin
      send_group(rand_group(4'b1111));
    end
    wr = '0;
    wait_drain();
    finish_test("full_groups");

    start_test();
    for (int i = 0; i < N_SPARSE; i++) begin
      send_group(rand_group(SPARSE_PAT[i % 12]));
    end
    wr = '0;
    wait_drain();
    finish_test("sparse_lanes");

    // Two full groups fill every bank
    start_test();
    rd_ready = 1'b0;
    send_group(rand_group(4'b1111));
    send_group(rand_group(4'b1111));
    g = rand_group(4'b1111);
    wr = g;
    saw_low = 1'b0;
    repeat (4) begin
      @(negedge clk);
      if (!in_ready) begin
        saw_low = 1'b1;
      end
    end
    @(posedge clk);
    #1;
    if (!saw_low) begin
      $display("in_ready never fell while the consumer was stalled");
      err_cnt++;
    end
    rd_ready = 1'b1;
    send_group(g);
    wr = '0;
    wait_drain();
    finish_test("back_pressure");

    start_test();
    rd_ready = 1'b0;
    send_group(rand_group(4'b0111));
    wr = '0;
    rd_ready = 1'b1;
    @(posedge clk);
    #1;
    rd_ready = 1'b0;
    @(negedge clk);
    if (rd.valid !== 2'b01) begin
      $display("Mismatch rd.valid: expected 1, actual %h", rd.valid);
      err_cnt++;
    end
    @(posedge clk);
    #1;
    rd_ready = 1'b1;
    wait_drain();
    @(negedge clk);
    if (idle !== 1'b1) begin
      $display("Mismatch idle: expected 1, actual %h", idle);
      err_cnt++;
    end
    if (rd.valid !== 2'b00) begin
      $display("Mismatch rd.valid: expected 0, actual %h", rd.valid);
      err_cnt++;
    end
    @(posedge clk);
    #1;
    finish_test("last_entry_drain");

    start_test();
    pending = 1'b0;
    for (int i = 0; i < N_RAND; i++) begin
      r = $random(seed);
      if (!pending) begin
        wr = rand_group(r[3:0]);
        pending = 1'b1;
      end
      rd_ready = r[4];
      @(negedge clk);
      if (in_ready) begin
        pending = 1'b0;
      end
      @(posedge clk);
      #1;
    end
    wr = '0;
    rd_ready = 1'b1;
    wait_drain();
    finish_test("random_mix");

    $display("%0d tests run, %0d failed, %0d errors", test_cnt, test_fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- dv/tb_clkgen.sv
`timescale 1ns/1ns

module tb_clkgen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Reset held for 8 cycles, released just after an edge
  initial begin
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

//--- filelist.f
+incdir+design
design/mwfifo_pkg.sv
design/fifo_flopped.sv
design/fifo_flopped_4w2r.sv
design/wide_push_packer.sv
design/pop_issuer.sv
design/mwfifo_top.sv
dv/tb_clkgen.sv
dv/mwfifo_tb.sv
